// ==== source/usb_rx_pkg.sv ====
// USB receive path shared definitions for PID codes, packet classes, FSM states and register map
package usb_rx_pkg;

	// Record width in bits, four byte lanes
	localparam int RECORD_W = 32;

	// PID upper nibble codes
	localparam logic [3:0] PID_DATA0 = 4'b0011;
	localparam logic [3:0] PID_DATA1 = 4'b1011;
	localparam logic [3:0] PID_DATA2 = 4'b0111;
	localparam logic [3:0] PID_MDATA = 4'b1111;
	localparam logic [3:0] PID_TOKEN_OUT = 4'b0001;
	localparam logic [3:0] PID_TOKEN_IN = 4'b1001;
	localparam logic [3:0] PID_SPECIAL_PRE = 4'b1100;
	localparam logic [3:0] PID_SPECIAL_SPLIT = 4'b1000;
	localparam logic [3:0] PID_SPECIAL_PING = 4'b0100;
	localparam logic [3:0] PID_HS_ACK = 4'b0010;
	localparam logic [3:0] PID_HS_NAK = 4'b1010;

	// Register byte offsets
	localparam logic [3:0] REG_STATUS = 4'h0;
	localparam logic [3:0] REG_HEAD = 4'h4;
	localparam logic [3:0] REG_POP = 4'h8;

	typedef enum logic [2:0] {DATA, TOKEN, SPECIAL, HANDSHAKE, UNKNOWN} pid_class_t;

	typedef enum logic [1:0] {IDLE, PAYLOAD, DATA_BYTE, CRC_BYTES} decode_state_t;

	// Sort a PID nibble into its packet class
	function automatic pid_class_t pid_class_of(input logic [3:0] nibble);
		pid_class_t cls;
		case (nibble)
			PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA: cls = DATA;
			PID_TOKEN_OUT, PID_TOKEN_IN: cls = TOKEN;
			PID_SPECIAL_PRE, PID_SPECIAL_SPLIT, PID_SPECIAL_PING: cls = SPECIAL;
			PID_HS_ACK, PID_HS_NAK: cls = HANDSHAKE;
			default: cls = UNKNOWN;
		endcase
		return cls;
	endfunction

endpackage

// ==== source/pid_decode.sv ====
// PID decoder that classifies each packet and sequences the per-byte enables of its payload
`timescale 1ns/10ps

module pid_decode
(
	input logic clk,
	input logic n_rst,
	input logic w_enable,
	input logic [7:0] rcv_data,
	output logic enable_pid,
	output logic enable_payload,
	output logic enable_pad,
	output logic packet_done
);

	usb_rx_pkg::decode_state_t state;
	usb_rx_pkg::decode_state_t next_state;
	usb_rx_pkg::pid_class_t pid_class;

	// Bytes still expected in the current phase
	logic [1:0] remaining;
	logic [1:0] next_remaining;
	logic done_next;

	// Class only matters on the PID strobe
	assign pid_class = usb_rx_pkg::pid_class_of(rcv_data[7:4]);

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			state <= usb_rx_pkg::IDLE;
			remaining <= 2'd0;
			packet_done <= 1'b0;
		end
		else
		begin
			state <= next_state;
			remaining <= next_remaining;
			// One cycle after the last byte
			packet_done <= done_next;
		end
	end

	always_comb
	begin
		enable_pid = 1'b0;
		enable_payload = 1'b0;
		enable_pad = 1'b0;
		done_next = 1'b0;
		next_state = state;
		next_remaining = remaining;

		case (state)
			usb_rx_pkg::IDLE:
			begin
				if (w_enable)
				begin
					enable_pid = 1'b1;
					case (pid_class)
						usb_rx_pkg::DATA:
						begin
							next_state = usb_rx_pkg::DATA_BYTE;
						end
						usb_rx_pkg::TOKEN, usb_rx_pkg::SPECIAL:
						begin
							next_state = usb_rx_pkg::PAYLOAD;
							next_remaining = 2'd2;
						end
						// Handshake or unknown, PID only
						default:
						begin
							done_next = 1'b1;
						end
					endcase
				end
			end

			usb_rx_pkg::PAYLOAD:
			begin
				if (w_enable)
				begin
					enable_payload = 1'b1;
					next_remaining = remaining - 2'd1;
					if (remaining == 2'd1)
					begin
						next_state = usb_rx_pkg::IDLE;
						done_next = 1'b1;
					end
				end
			end

			usb_rx_pkg::DATA_BYTE:
			begin
				if (w_enable)
				begin
					enable_payload = 1'b1;
					// Two CRC bytes follow the data byte
					next_state = usb_rx_pkg::CRC_BYTES;
					next_remaining = 2'd2;
				end
			end

			default:
			begin
				if (w_enable)
				begin
					enable_pad = 1'b1;
					next_remaining = remaining - 2'd1;
					if (remaining == 2'd1)
					begin
						next_state = usb_rx_pkg::IDLE;
						done_next = 1'b1;
					end
				end
			end
		endcase
	end

endmodule

// ==== source/packet_assembler.sv ====
// Packet assembler that packs the PID and following bytes into one record and pushes it once
`timescale 1ns/10ps

module packet_assembler
(
	input logic clk,
	input logic n_rst,
	input logic [7:0] rcv_data,
	input logic enable_pid,
	input logic enable_payload,
	input logic enable_pad,
	input logic packet_done,
	output logic push_valid,
	output logic [usb_rx_pkg::RECORD_W-1:0] push_record
);

	usb_rx_pkg::pid_class_t pid_class;
	logic [usb_rx_pkg::RECORD_W-1:0] record_q;

	// Next byte lane to fill
	logic [1:0] lane;
	// Lanes the packet class still allows
	logic [1:0] bytes_left;
	logic byte_en;

	assign pid_class = usb_rx_pkg::pid_class_of(rcv_data[7:4]);
	assign byte_en = (enable_payload || enable_pad) && (bytes_left != 2'd0);

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			lane <= 2'd0;
			bytes_left <= 2'd0;
			push_valid <= 1'b0;
		end
		else
		begin
			push_valid <= packet_done;
			if (enable_pid)
			begin
				lane <= 2'd1;
				case (pid_class)
					usb_rx_pkg::DATA: bytes_left <= 2'd3;
					usb_rx_pkg::TOKEN, usb_rx_pkg::SPECIAL: bytes_left <= 2'd2;
					default: bytes_left <= 2'd0;
				endcase
			end
			else if (byte_en)
			begin
				lane <= lane + 2'd1;
				bytes_left <= bytes_left - 2'd1;
			end
		end
	end

	// PID in lane 0, upper lanes cleared
	always_ff @(posedge clk)
	begin
		if (enable_pid)
			record_q <= {{(usb_rx_pkg::RECORD_W-8){1'b0}}, rcv_data};
		else if (byte_en)
			record_q[{lane, 3'b000} +: 8] <= rcv_data;
	end

	// Record is stable for the push cycle
	assign push_record = record_q;

endmodule

// ==== source/record_store.sv ====
// Record store holding a ring of packet records in one RAM with a fixed-priority port arbiter
`timescale 1ns/10ps

module record_store
#(
	parameter int DEPTH_LOG2 = 3
)
(
	input logic clk,
	input logic n_rst,
	input logic push_valid,
	input logic [usb_rx_pkg::RECORD_W-1:0] push_record,
	input logic head_req,
	input logic pop,
	input logic overflow_clear,
	output logic [usb_rx_pkg::RECORD_W-1:0] head_record,
	output logic head_ack,
	output logic [DEPTH_LOG2:0] count,
	output logic overflow
);

	localparam int DEPTH = 1 << DEPTH_LOG2;
	localparam logic [DEPTH_LOG2:0] FULL_COUNT = {1'b1, {DEPTH_LOG2{1'b0}}};

	logic [usb_rx_pkg::RECORD_W-1:0] mem [DEPTH];
	logic [DEPTH_LOG2-1:0] head;
	logic [DEPTH_LOG2-1:0] tail;
	logic req_pend;
	logic serve;
	logic push_ok;
	logic pop_ok;
	logic empty;

	assign empty = (count == '0);
	assign push_ok = push_valid && (count != FULL_COUNT);
	assign pop_ok = pop && !empty;
	// Writer owns the port whenever it pushes
	assign serve = (head_req || req_pend) && !push_valid;

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			overflow <= 1'b0;
			req_pend <= 1'b0;
			head_ack <= 1'b0;
		end
		else
		begin
			req_pend <= (head_req || req_pend) && push_valid;
			head_ack <= serve;
			if (push_ok)
				tail <= tail + 1'b1;
			if (pop_ok)
				head <= head + 1'b1;
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
			// Dropped push wins over a clear in the same cycle
			if (push_valid && !push_ok)
				overflow <= 1'b1;
			else if (overflow_clear)
				overflow <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push_ok)
			mem[tail] <= push_record;
		if (serve)
			head_record <= empty ? '0 : mem[head];
	end

endmodule

// ==== source/axil_rx_regs.sv ====
// AXI4-Lite slave exposing the STATUS, HEAD and POP registers of the record store
`timescale 1ns/10ps

module axil_rx_regs
#(
	parameter int DEPTH_LOG2 = 3
)
(
	input logic clk,
	input logic n_rst,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic [usb_rx_pkg::RECORD_W-1:0] head_record,
	input logic head_ack,
	input logic [DEPTH_LOG2:0] count,
	input logic overflow,
	output logic head_req,
	output logic pop,
	output logic overflow_clear
);

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic [1:0] {R_IDLE, R_WAIT, R_RESP} rd_state_t;

	rd_state_t rd_state;
	logic [3:0] raddr;
	logic [31:0] status_word;
	logic ar_fire;
	logic wr_fire;
	logic is_pop;

	assign arready = (rd_state == R_IDLE);
	assign rvalid = (rd_state == R_RESP);
	assign ar_fire = arvalid && arready;
	// Store request goes out on the AR handshake itself
	assign head_req = ar_fire && (araddr == usb_rx_pkg::REG_HEAD);

	// Both channels taken together, one response outstanding
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign is_pop = (awaddr == usb_rx_pkg::REG_POP);

	// Count in the low bits, overflow in bit 31
	always_comb
	begin
		status_word = '0;
		status_word[DEPTH_LOG2:0] = count;
		status_word[31] = overflow;
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			rd_state <= R_IDLE;
			bvalid <= 1'b0;
			pop <= 1'b0;
			overflow_clear <= 1'b0;
		end
		else
		begin
			case (rd_state)
				R_IDLE: if (ar_fire) rd_state <= R_WAIT;
				R_WAIT: if (raddr != usb_rx_pkg::REG_HEAD || head_ack) rd_state <= R_RESP;
				default: if (rready) rd_state <= R_IDLE;
			endcase
			pop <= wr_fire && is_pop;
			overflow_clear <= wr_fire && is_pop && wstrb[0] && wdata[1];
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ar_fire)
			raddr <= araddr;
		if (wr_fire)
			bresp <= (awaddr inside {usb_rx_pkg::REG_STATUS, usb_rx_pkg::REG_HEAD,
				usb_rx_pkg::REG_POP}) ? RESP_OKAY : RESP_SLVERR;
		// HEAD keeps sampling until the ack cycle
		if (rd_state == R_WAIT)
		begin
			rresp <= RESP_OKAY;
			case (raddr)
				usb_rx_pkg::REG_STATUS: rdata <= status_word;
				usb_rx_pkg::REG_HEAD: rdata <= head_record;
				usb_rx_pkg::REG_POP: rdata <= '0;
				default:
				begin
					rdata <= '0;
					rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

// ==== source/usb_rx_top.sv ====
// USB receive path top level joining decoder, assembler, record store and AXI4-Lite registers
`timescale 1ns/10ps

module usb_rx_top
#(
	parameter int DEPTH_LOG2 = 3
)
(
	input logic clk,
	input logic n_rst,
	input logic w_enable,
	input logic [7:0] rcv_data,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	// Decoder to assembler
	logic enable_pid;
	logic enable_payload;
	logic enable_pad;
	logic packet_done;

	// Assembler and register block to store
	logic push_valid;
	logic [usb_rx_pkg::RECORD_W-1:0] push_record;
	logic head_req;
	logic pop;
	logic overflow_clear;
	logic [usb_rx_pkg::RECORD_W-1:0] head_record;
	logic head_ack;
	logic [DEPTH_LOG2:0] count;
	logic overflow;

	pid_decode u_dec (
		.clk(clk), .n_rst(n_rst), .w_enable(w_enable), .rcv_data(rcv_data),
		.enable_pid(enable_pid), .enable_payload(enable_payload),
		.enable_pad(enable_pad), .packet_done(packet_done)
	);

	packet_assembler u_asm (
		.clk(clk), .n_rst(n_rst), .rcv_data(rcv_data), .enable_pid(enable_pid),
		.enable_payload(enable_payload), .enable_pad(enable_pad),
		.packet_done(packet_done), .push_valid(push_valid), .push_record(push_record)
	);

	record_store #(.DEPTH_LOG2(DEPTH_LOG2)) u_store (
		.clk(clk), .n_rst(n_rst), .push_valid(push_valid), .push_record(push_record),
		.head_req(head_req), .pop(pop), .overflow_clear(overflow_clear),
		.head_record(head_record), .head_ack(head_ack), .count(count), .overflow(overflow)
	);

	axil_rx_regs #(.DEPTH_LOG2(DEPTH_LOG2)) u_regs (
		.clk(clk), .n_rst(n_rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.head_record(head_record), .head_ack(head_ack), .count(count), .overflow(overflow),
		.head_req(head_req), .pop(pop), .overflow_clear(overflow_clear)
	);

endmodule

// ==== testbench/usb_rx_asserts.sv ====
// Protocol assertions for the USB receive path, bound into its top level
`timescale 1ns/10ps

module usb_rx_asserts
(
	input logic clk,
	input logic n_rst,
	input logic w_enable,
	input logic enable_pid,
	input logic enable_payload,
	input logic enable_pad,
	input logic push_valid,
	input logic [31:0] rdata,
	input logic rvalid,
	input logic rready,
	input logic bvalid,
	input logic bready
);

	// Decoder enables are exclusive
	a_one_enable: assert property (@(posedge clk) disable iff (!n_rst)
		$onehot0({enable_pid, enable_payload, enable_pad}))
	else $error("More than one decoder enable high");

	// Enables only on a byte strobe
	a_enable_strobe: assert property (@(posedge clk) disable iff (!n_rst)
		(enable_pid || enable_payload || enable_pad) |-> w_enable)
	else $error("Decoder enable without w_enable");

	a_push_pulse: assert property (@(posedge clk) disable iff (!n_rst)
		push_valid |=> !push_valid)
	else $error("push_valid longer than one cycle");

	// Read data held with rvalid
	a_rvalid_hold: assert property (@(posedge clk) disable iff (!n_rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else $error("rvalid or rdata changed before rready");

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!n_rst)
		bvalid && !bready |=> bvalid)
	else $error("bvalid dropped before bready");

endmodule

bind usb_rx_top usb_rx_asserts u_asserts (.*);

// ==== testbench/tb_usb_rx.sv ====
// Testbench for the USB receive path, sending packets and checking records over AXI4-Lite
`timescale 1ns/10ps

module tb_usb_rx;

	localparam int DEPTH_LOG2 = 3;
	localparam int DEPTH = 1 << DEPTH_LOG2;
	localparam int N_PKT = 12;
	// 26 packets of up to 4 bytes at a gap of 5, about 96 bus transfers of 8 cycles
	localparam int TIMEOUT = 4 * (26 * 4 * 5 + 96 * 8);

	logic clk = 1'b0;
	logic n_rst;
	logic w_enable;
	logic [7:0] rcv_data;
	logic [3:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [3:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	logic [31:0] lfsr = 32'h4b6f_b967;

	// Columns: PID, payload {b3, b2, b1}, payload length, expected record
	logic [71:0] pkt_tbl [N_PKT] = '{
		{8'h3C, 24'h22115A, 8'd3, 32'h22115A3C},
		{8'h1E, 24'h001234, 8'd2, 32'h0012341E},
		{8'hC3, 24'h00807F, 8'd2, 32'h00807FC3},
		{8'h2D, 24'h000000, 8'd0, 32'h0000002D},
		{8'h6A, 24'h000000, 8'd0, 32'h0000006A},
		{8'hB4, 24'hC3B2A1, 8'd3, 32'hC3B2A1B4},
		{8'h96, 24'h00F001, 8'd2, 32'h00F00196},
		{8'h87, 24'h00AA55, 8'd2, 32'h00AA5587},
		{8'hA5, 24'h000000, 8'd0, 32'h000000A5},
		{8'h78, 24'hD2E10F, 8'd3, 32'hD2E10F78},
		{8'hF0, 24'h778899, 8'd3, 32'h778899F0},
		{8'h4B, 24'h00C33C, 8'd2, 32'h00C33C4B}
	};

	usb_rx_top #(.DEPTH_LOG2(DEPTH_LOG2)) u_dut (.*);

	always #5 clk = ~clk;

	// Run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT)
		begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// Gap of 2 to 5 cycles
	function automatic int rand_gap();
		int g;
		g = 2;
		g += int'(lfsr_bit());
		g += 2 * int'(lfsr_bit());
		return g;
	endfunction

	function automatic logic [31:0] expect_status(input int cnt, input logic ovf);
		return {ovf, 31'(cnt)};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			value_errors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_latency(input int lat);
		assert (lat <= 3)
		else
		begin
			other_errors++;
			$display("HEAD read answered %0d cycles after the address handshake", lat);
		end
	endtask

	// Strobe one byte, gap counted from the previous strobe
	task automatic send_byte(input logic [7:0] b, input int gap);
		repeat (gap - 1) @(posedge clk);
		w_enable <= 1'b1;
		rcv_data <= b;
		@(posedge clk);
		w_enable <= 1'b0;
	endtask

	task automatic send_packet(input int idx);
		logic [71:0] row;
		int len;
		int k;
		row = pkt_tbl[idx];
		len = int'(row[39:32]);
		send_byte(row[71:64], rand_gap());
		for (k = 0; k < len; k++)
			send_byte(row[40 + 8 * k +: 8], rand_gap());
	endtask

	// Done, push, then count update
	task automatic wait_push();
		repeat (2) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp, output int lat);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		arvalid <= 1'b0;
		// Cycles from the AR handshake cycle to the first rvalid cycle
		lat = 1;
		do
		begin
			@(posedge clk);
			lat++;
			@(negedge clk);
		end
		while (!rvalid);
		data = rdata;
		resp = rresp;
		// Late rready keeps rvalid waiting a cycle
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'hf;
		wvalid <= 1'b1;
		@(negedge clk);
		while (!(awready && wready))
			@(negedge clk);
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic check_status(input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0] resp;
		int lat;
		axil_read(usb_rx_pkg::REG_STATUS, data, resp, lat);
		check_value("STATUS rdata", data, exp);
		check_value("STATUS rresp", 32'(resp), 32'h0);
	endtask

	task automatic read_and_pop(input logic [31:0] exp, input logic [31:0] pop_data);
		logic [31:0] data;
		logic [1:0] resp;
		int lat;
		axil_read(usb_rx_pkg::REG_HEAD, data, resp, lat);
		check_value("HEAD rdata", data, exp);
		check_value("HEAD rresp", 32'(resp), 32'h0);
		check_latency(lat);
		axil_write(usb_rx_pkg::REG_POP, pop_data, resp);
		check_value("POP bresp", 32'(resp), 32'h0);
	endtask

	initial
	begin
		logic [31:0] data;
		logic [1:0] resp;
		int lat;
		int got;
		n_rst = 1'b0;
		w_enable = 1'b0;
		rcv_data = 8'h00;
		awaddr = 4'h0;
		awvalid = 1'b0;
		wdata = 32'h0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 4'h0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (5) @(posedge clk);
		n_rst <= 1'b1;

		// One packet per class, count rises 3 cycles after the last strobe
		for (int i = 0; i < 5; i++)
		begin
			send_packet(i);
			wait_push();
			check_value("count", 32'(u_dut.count), 32'h1);
			read_and_pop(pkt_tbl[i][31:0], 32'h0);
		end

		// Five queued, drained in order
		for (int i = 5; i < 10; i++)
			send_packet(i);
		wait_push();
		check_status(expect_status(5, 1'b0));
		for (int i = 5; i < 10; i++)
			read_and_pop(pkt_tbl[i][31:0], 32'h0);
		check_status(expect_status(0, 1'b0));

		// Overflow keeps the oldest records
		for (int i = 0; i < DEPTH + 2; i++)
			send_packet(i);
		wait_push();
		check_status(expect_status(DEPTH, 1'b1));
		read_and_pop(pkt_tbl[0][31:0], 32'h2);
		check_status(expect_status(DEPTH - 1, 1'b0));
		for (int i = 1; i < DEPTH; i++)
			read_and_pop(pkt_tbl[i][31:0], 32'h0);
		check_status(expect_status(0, 1'b0));

		// HEAD reads racing pushes, zero means empty
		fork
			begin
				for (int i = 6; i < N_PKT; i++)
					send_packet(i);
			end
			begin
				got = 0;
				while (got < N_PKT - 6)
				begin
					axil_read(usb_rx_pkg::REG_HEAD, data, resp, lat);
					check_latency(lat);
					if (data != 32'h0)
					begin
						check_value("HEAD rdata", data, pkt_tbl[6 + got][31:0]);
						axil_write(usb_rx_pkg::REG_POP, 32'h0, resp);
						got++;
					end
				end
			end
		join
		check_status(expect_status(0, 1'b0));

		// Unmapped read, then POP of an empty store
		axil_read(4'hC, data, resp, lat);
		check_value("unmapped rdata", data, 32'h0);
		check_value("unmapped rresp", 32'(resp), 32'h2);
		axil_write(usb_rx_pkg::REG_POP, 32'h0, resp);
		check_status(expect_status(0, 1'b0));

		$display("Errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== all.f ====
source/usb_rx_pkg.sv
source/pid_decode.sv
source/packet_assembler.sv
source/record_store.sv
source/axil_rx_regs.sv
source/usb_rx_top.sv
testbench/usb_rx_asserts.sv
testbench/tb_usb_rx.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the USB receive path testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_usb_rx -f all.f \
	|| { echo "Build failed"; exit 1; }
./obj_dir/Vtb_usb_rx > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
